//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the event control testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f src.f --top-module tb_event_control \
    --Mdir "$BUILD_DIR" -o tb_event_control
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_event_control" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG_FILE"; then
    exit 0
else
    echo "pass message not found in $LOG_FILE"
    exit 1
fi

//--- sim/tb_event_control.sv
`timescale 1ns/10ps

`include "event_ctrl_config.svh"

module tb_event_control;

    localparam logic [31:0] LFSR_SEED = 32'hbeb7_7d7f;
    localparam int NUM_CTRL_WRITES   = 8;
    localparam int NUM_COUNT_CYCLES  = 40;
    localparam int NUM_STATUS_ROUNDS = 3;
    localparam int DDR_DELAY         = `EVENT_DDR_RESET_DELAY;
    // one bus access from request to release takes about four cycles
    localparam int BUS_CYCLES = 4;
    localparam int TIMEOUT_CYCLES = 16 + 2 * BUS_CYCLES
        + NUM_CTRL_WRITES * (2 * BUS_CYCLES + 1) + BUS_CYCLES
        + 20 * BUS_CYCLES + 35
        + NUM_COUNT_CYCLES + 7 * BUS_CYCLES
        + NUM_STATUS_ROUNDS * (6 * BUS_CYCLES + 1)
        + 3 * BUS_CYCLES + 3 * (DDR_DELAY + 2)
        + 100;

    logic                        memclk;
    logic                        arst_n_i;
    logic                        wb_cyc_i;
    logic                        wb_stb_i;
    logic                        wb_we_i;
    event_bus_pkg::wb_addr_t     wb_adr_i;
    event_bus_pkg::wb_sel_t      wb_sel_i;
    event_bus_pkg::wb_data_t     wb_dat_i;
    logic                        wb_ack_o;
    event_bus_pkg::wb_data_t     wb_dat_o;
    logic                        event_open_i;
    event_stat_pkg::track_err_t  track_err_i;
    event_stat_pkg::err_vec_t    lane_err_i;
    event_stat_pkg::err_vec_t    mem_err_i;
    event_stat_pkg::err_vec_t    readout_err_i;
    event_stat_pkg::ack_count_t  ack_count_i;
    event_stat_pkg::flow_count_t allow_count_i;
    event_stat_pkg::flow_count_t cmpl_count_i;
    event_stat_pkg::lane_valid_t lane_valid_i;
    logic                        tx_qword_i;
    logic                        tx_event_i;
    logic                        event_reset_o;
    logic                        ddr_reset_o;
    event_stat_pkg::tio_mask_t   tio_mask_o;
    event_stat_pkg::runcfg_t     runcfg_o;

    int          error_count;
    int          check_count;
    int          cycle_count;
    logic [31:0] lfsr_state;

    // software view of the global register
    logic                       model_force;
    logic                       model_ddr;
    event_stat_pkg::tio_mask_t  model_mask;
    event_stat_pkg::runcfg_t    model_runcfg;
    event_stat_pkg::track_err_t model_track;

    event_control_top DUT (
        .memclk        (memclk),
        .arst_n_i      (arst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_o      (wb_ack_o),
        .wb_dat_o      (wb_dat_o),
        .event_open_i  (event_open_i),
        .track_err_i   (track_err_i),
        .lane_err_i    (lane_err_i),
        .mem_err_i     (mem_err_i),
        .readout_err_i (readout_err_i),
        .ack_count_i   (ack_count_i),
        .allow_count_i (allow_count_i),
        .cmpl_count_i  (cmpl_count_i),
        .lane_valid_i  (lane_valid_i),
        .tx_qword_i    (tx_qword_i),
        .tx_event_i    (tx_event_i),
        .event_reset_o (event_reset_o),
        .ddr_reset_o   (ddr_reset_o),
        .tio_mask_o    (tio_mask_o),
        .runcfg_o      (runcfg_o)
    );

    initial begin
        memclk = 1'b0;
        forever #50 memclk = ~memclk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge memclk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_data(input string name, input event_bus_pkg::wb_data_t got,
                              input event_bus_pkg::wb_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_mask(input event_stat_pkg::tio_mask_t got,
                              input event_stat_pkg::tio_mask_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL tio_mask_o: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_runcfg(input event_stat_pkg::runcfg_t got,
                                input event_stat_pkg::runcfg_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL runcfg_o: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic wb_write(input event_bus_pkg::reg_index_t idx,
                            input event_bus_pkg::wb_sel_t sel,
                            input event_bus_pkg::wb_data_t data);
        @(posedge memclk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= {7'd0, idx, 2'b00};
        wb_sel_i <= sel;
        wb_dat_i <= data;
        @(negedge memclk);
        while (!wb_ack_o) begin
            @(negedge memclk);
        end
        // the write lands on this edge
        @(posedge memclk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic wb_read(input event_bus_pkg::reg_index_t idx,
                           output event_bus_pkg::wb_data_t data);
        @(posedge memclk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= {7'd0, idx, 2'b00};
        wb_sel_i <= 4'hf;
        @(negedge memclk);
        while (!wb_ack_o) begin
            @(negedge memclk);
        end
        data = wb_dat_o;
        @(posedge memclk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    function automatic void update_model(input event_bus_pkg::wb_sel_t sel,
                                         input event_bus_pkg::wb_data_t data);
        if (sel[0]) begin
            model_force = data[0];
            model_ddr   = data[2];
        end
        if (sel[1]) begin
            model_mask = data[11:8];
        end
        if (sel[2]) begin
            model_runcfg[7:0] = data[23:16];
        end
        if (sel[3]) begin
            model_runcfg[11:8] = data[27:24];
        end
    endfunction

    function automatic event_bus_pkg::wb_data_t expected_global(input logic evr);
        return {4'd0, model_runcfg, model_track, model_mask, 5'd0, model_ddr, evr, model_force};
    endfunction

    task automatic test_reset_state();
        event_bus_pkg::wb_data_t rd;
        @(negedge memclk);
        check_bit("wb_ack_o", wb_ack_o, 1'b0);
        check_bit("event_reset_o", event_reset_o, 1'b0);
        check_bit("ddr_reset_o", ddr_reset_o, 1'b0);
        check_mask(tio_mask_o, 4'h0);
        check_runcfg(runcfg_o, 12'h000);
        check_data("wb_dat_o", wb_dat_o, 32'h0);
        // event is closed so only the event reset bit is set
        wb_read(4'd0, rd);
        check_data("global reg", rd, 32'h0000_0002);
    endtask

    task automatic test_control_writes();
        logic [31:0]             data;
        logic [31:0]             v;
        event_bus_pkg::wb_sel_t  sel;
        event_bus_pkg::wb_data_t rd;
        for (int n = 0; n < NUM_CTRL_WRITES; n++) begin
            random_bits(32, data);
            random_bits(4, v);
            sel = v[3:0];
            random_bits(2, v);
            // any alias of the global register
            wb_write({2'b00, v[1:0]}, sel, data);
            update_model(sel, data);
            wb_read(4'd0, rd);
            check_data("global reg", rd, expected_global(1'b1));
            @(negedge memclk);
            check_mask(tio_mask_o, model_mask);
            check_runcfg(runcfg_o, model_runcfg);
        end
        wb_write(4'd0, 4'hf, 32'h0);
        update_model(4'hf, 32'h0);
    endtask

    task automatic pulse_valids(input int n);
        @(posedge memclk);
        lane_valid_i <= 4'hf;
        tx_qword_i   <= 1'b1;
        tx_event_i   <= 1'b1;
        repeat (n) @(posedge memclk);
        lane_valid_i <= 4'h0;
        tx_qword_i   <= 1'b0;
        tx_event_i   <= 1'b0;
    endtask

    task automatic check_counts_zero();
        event_bus_pkg::wb_data_t rd;
        for (int r = 4; r <= 9; r++) begin
            wb_read(event_bus_pkg::reg_index_t'(r), rd);
            check_data($sformatf("count reg %0d", r), rd, 32'h0);
        end
    endtask

    task automatic test_event_reset();
        event_bus_pkg::wb_data_t rd;
        @(negedge memclk);
        check_bit("event_reset_o", event_reset_o, 1'b1);
        pulse_valids(4);
        check_counts_zero();
        @(posedge memclk);
        event_open_i <= 1'b1;
        @(posedge memclk);
        @(negedge memclk);
        check_bit("event_reset_o", event_reset_o, 1'b0);
        // counts run up while the event is open
        pulse_valids(4);
        // force bit clears the statistics with the event open
        wb_write(4'd0, 4'h1, 32'h0000_0001);
        update_model(4'h1, 32'h0000_0001);
        @(posedge memclk);
        @(negedge memclk);
        check_bit("event_reset_o", event_reset_o, 1'b1);
        pulse_valids(4);
        check_counts_zero();
        wb_read(4'd0, rd);
        check_data("global reg", rd, expected_global(1'b1));
        wb_write(4'd0, 4'h1, 32'h0);
        update_model(4'h1, 32'h0);
        @(posedge memclk);
        @(negedge memclk);
        check_bit("event_reset_o", event_reset_o, 1'b0);
        wb_read(4'd0, rd);
        check_data("global reg", rd, expected_global(1'b0));
    endtask

    task automatic test_counters();
        logic [31:0]             v;
        event_bus_pkg::wb_data_t rd;
        event_stat_pkg::count_t  exp_lane [`EVENT_NUM_LANES];
        event_stat_pkg::count_t  exp_qword;
        event_stat_pkg::count_t  exp_event;
        for (int l = 0; l < `EVENT_NUM_LANES; l++) begin
            exp_lane[l] = '0;
        end
        exp_qword = '0;
        exp_event = '0;
        for (int c = 0; c < NUM_COUNT_CYCLES; c++) begin
            random_bits(6, v);
            @(posedge memclk);
            lane_valid_i <= v[3:0];
            tx_qword_i   <= v[4];
            tx_event_i   <= v[5];
            for (int l = 0; l < `EVENT_NUM_LANES; l++) begin
                if (v[l]) begin
                    exp_lane[l] = exp_lane[l] + 32'd1;
                end
            end
            if (v[4]) begin
                exp_qword = exp_qword + 32'd1;
            end
            if (v[5]) begin
                exp_event = exp_event + 32'd1;
            end
        end
        @(posedge memclk);
        lane_valid_i <= 4'h0;
        tx_qword_i   <= 1'b0;
        tx_event_i   <= 1'b0;
        for (int l = 0; l < `EVENT_NUM_LANES; l++) begin
            wb_read(event_bus_pkg::reg_index_t'(4 + l), rd);
            check_data($sformatf("lane count %0d", l), rd, exp_lane[l]);
        end
        wb_read(4'd8, rd);
        check_data("qword count", rd, exp_qword);
        wb_read(4'd9, rd);
        check_data("event count", rd, exp_event);
        wb_read(4'd15, rd);
        check_data("lane count 3 copy", rd, exp_lane[3]);
    endtask

    task automatic test_status();
        logic [31:0]             lane_err;
        logic [31:0]             mem_err;
        logic [31:0]             ro_err;
        logic [31:0]             v;
        logic [31:0]             ack;
        logic [31:0]             allow;
        logic [31:0]             cmpl;
        event_bus_pkg::wb_data_t rd;
        for (int n = 0; n < NUM_STATUS_ROUNDS; n++) begin
            random_bits(32, lane_err);
            random_bits(32, mem_err);
            random_bits(32, ro_err);
            random_bits(4, v);
            random_bits(12, ack);
            random_bits(13, allow);
            random_bits(13, cmpl);
            @(posedge memclk);
            lane_err_i    <= lane_err;
            mem_err_i     <= mem_err;
            readout_err_i <= ro_err;
            track_err_i   <= v[3:0];
            ack_count_i   <= ack[11:0];
            allow_count_i <= allow[12:0];
            cmpl_count_i  <= cmpl[12:0];
            model_track = v[3:0];
            wb_read(4'd0, rd);
            check_data("global reg", rd, expected_global(1'b0));
            wb_read(4'd10, rd);
            check_data("flow count reg", rd, {3'd0, allow[12:0], 4'd0, ack[11:0]});
            wb_read(4'd11, rd);
            check_data("lane error reg", rd, lane_err);
            wb_read(4'd12, rd);
            check_data("memory error reg", rd, mem_err);
            wb_read(4'd13, rd);
            check_data("readout error reg", rd, ro_err);
            wb_read(4'd14, rd);
            check_data("completion count reg", rd, {19'd0, cmpl[12:0]});
        end
    endtask

    // the request is visible just after the ack cycle closes
    task automatic follow_ddr_delay(input logic level);
        logic exp;
        for (int i = 1; i <= DDR_DELAY + 1; i++) begin
            @(negedge memclk);
            exp = (i > DDR_DELAY) ? level : ~level;
            check_bit($sformatf("ddr_reset_o, cycle %0d", i), ddr_reset_o, exp);
        end
    endtask

    task automatic test_ddr_delay();
        wb_write(4'd0, 4'h1, 32'h0);
        update_model(4'h1, 32'h0);
        repeat (DDR_DELAY + 2) @(posedge memclk);
        @(negedge memclk);
        check_bit("ddr_reset_o", ddr_reset_o, 1'b0);
        wb_write(4'd0, 4'h1, 32'h0000_0004);
        update_model(4'h1, 32'h0000_0004);
        follow_ddr_delay(1'b1);
        wb_write(4'd0, 4'h1, 32'h0);
        update_model(4'h1, 32'h0);
        follow_ddr_delay(1'b0);
    endtask

    initial begin
        error_count  = 0;
        check_count  = 0;
        lfsr_state   = LFSR_SEED;
        model_force  = 1'b0;
        model_ddr    = 1'b0;
        model_mask   = '0;
        model_runcfg = '0;
        model_track  = '0;
        arst_n_i      <= 1'b0;
        wb_cyc_i      <= 1'b0;
        wb_stb_i      <= 1'b0;
        wb_we_i       <= 1'b0;
        wb_adr_i      <= '0;
        wb_sel_i      <= '0;
        wb_dat_i      <= '0;
        event_open_i  <= 1'b0;
        track_err_i   <= '0;
        lane_err_i    <= '0;
        mem_err_i     <= '0;
        readout_err_i <= '0;
        ack_count_i   <= '0;
        allow_count_i <= '0;
        cmpl_count_i  <= '0;
        lane_valid_i  <= '0;
        tx_qword_i    <= 1'b0;
        tx_event_i    <= 1'b0;
        repeat (16) @(posedge memclk);
        arst_n_i <= 1'b1;
        test_reset_state();
        test_control_writes();
        test_event_reset();
        test_counters();
        test_status();
        test_ddr_delay();
        repeat (2) @(posedge memclk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- source/ddr_reset_delay.sv
`timescale 1ns/10ps

`include "event_ctrl_config.svh"

module ddr_reset_delay #(
    parameter int DELAY = `EVENT_DDR_RESET_DELAY
) (
    input  logic memclk,
    input  logic arst_n_i,
    input  logic req_i,
    output logic ddr_reset_o
);

    logic [DELAY-1:0] shift_q;

    // the memory controller only sees a request that has settled
    // for DELAY cycles
    always_ff @(posedge memclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shift_q <= '0;
        end else begin
            shift_q[0] <= req_i;
            for (int i = 1; i < DELAY; i++) begin
                shift_q[i] <= shift_q[i-1];
            end
        end
    end

    assign ddr_reset_o = shift_q[DELAY-1];

endmodule

//--- source/event_bus_pkg.sv
package event_bus_pkg;

    // wishbone slave signals
    typedef logic [12:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // register index, byte address bits 5:2
    typedef logic [3:0] reg_index_t;

    // register map, indices 0 to 3 all alias the global register
    localparam reg_index_t REG_GLOBAL         = 4'd0;
    localparam reg_index_t REG_LANE_CNT0      = 4'd4;
    localparam reg_index_t REG_LANE_CNT1      = 4'd5;
    localparam reg_index_t REG_LANE_CNT2      = 4'd6;
    localparam reg_index_t REG_LANE_CNT3      = 4'd7;
    localparam reg_index_t REG_QWORD_CNT      = 4'd8;
    localparam reg_index_t REG_EVENT_CNT      = 4'd9;
    localparam reg_index_t REG_FLOW_CNT       = 4'd10;
    localparam reg_index_t REG_LANE_ERR       = 4'd11;
    localparam reg_index_t REG_MEM_ERR        = 4'd12;
    localparam reg_index_t REG_READOUT_ERR    = 4'd13;
    localparam reg_index_t REG_CMPL_CNT       = 4'd14;
    localparam reg_index_t REG_LANE_CNT3_COPY = 4'd15;

endpackage

//--- source/event_control_top.sv
`timescale 1ns/10ps

`include "event_ctrl_config.svh"

module event_control_top (
    input  logic                        memclk,
    input  logic                        arst_n_i,

    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  event_bus_pkg::wb_addr_t     wb_adr_i,
    input  event_bus_pkg::wb_sel_t      wb_sel_i,
    input  event_bus_pkg::wb_data_t     wb_dat_i,
    output logic                        wb_ack_o,
    output event_bus_pkg::wb_data_t     wb_dat_o,

    input  logic                        event_open_i,
    input  event_stat_pkg::track_err_t  track_err_i,
    input  event_stat_pkg::err_vec_t    lane_err_i,
    input  event_stat_pkg::err_vec_t    mem_err_i,
    input  event_stat_pkg::err_vec_t    readout_err_i,
    input  event_stat_pkg::ack_count_t  ack_count_i,
    input  event_stat_pkg::flow_count_t allow_count_i,
    input  event_stat_pkg::flow_count_t cmpl_count_i,

    input  event_stat_pkg::lane_valid_t lane_valid_i,
    input  logic                        tx_qword_i,
    input  logic                        tx_event_i,

    output logic                        event_reset_o,
    output logic                        ddr_reset_o,
    output event_stat_pkg::tio_mask_t   tio_mask_o,
    output event_stat_pkg::runcfg_t     runcfg_o
);

    logic                   ddr_reset_req;
    event_stat_pkg::count_t lane_count [`EVENT_NUM_LANES];
    event_stat_pkg::count_t tx_count [`EVENT_NUM_TX_COUNTS];

    event_register_core u_core (
        .memclk          (memclk),
        .arst_n_i        (arst_n_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_sel_i        (wb_sel_i),
        .wb_dat_i        (wb_dat_i),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .event_open_i    (event_open_i),
        .track_err_i     (track_err_i),
        .lane_err_i      (lane_err_i),
        .mem_err_i       (mem_err_i),
        .readout_err_i   (readout_err_i),
        .ack_count_i     (ack_count_i),
        .allow_count_i   (allow_count_i),
        .cmpl_count_i    (cmpl_count_i),
        .lane_count_i    (lane_count),
        .tx_count_i      (tx_count),
        .event_reset_o   (event_reset_o),
        .ddr_reset_req_o (ddr_reset_req),
        .tio_mask_o      (tio_mask_o),
        .runcfg_o        (runcfg_o)
    );

    event_stat_counter #(
        .NUM_COUNTS (`EVENT_NUM_LANES)
    ) u_lane_stat (
        .memclk   (memclk),
        .arst_n_i (arst_n_i),
        .clear_i  (event_reset_o),
        .valid_i  (lane_valid_i),
        .count_o  (lane_count)
    );

    // qword count at index 0, event count at index 1
    event_stat_counter #(
        .NUM_COUNTS (`EVENT_NUM_TX_COUNTS)
    ) u_tx_stat (
        .memclk   (memclk),
        .arst_n_i (arst_n_i),
        .clear_i  (event_reset_o),
        .valid_i  ({tx_event_i, tx_qword_i}),
        .count_o  (tx_count)
    );

    ddr_reset_delay #(
        .DELAY (`EVENT_DDR_RESET_DELAY)
    ) u_ddr_reset_delay (
        .memclk      (memclk),
        .arst_n_i    (arst_n_i),
        .req_i       (ddr_reset_req),
        .ddr_reset_o (ddr_reset_o)
    );

endmodule

//--- source/event_ctrl_config.svh
`ifndef EVENT_CTRL_CONFIG_SVH
`define EVENT_CTRL_CONFIG_SVH

// sizing of the event-path control block

// valid lanes counted by the lane statistics bank
`define EVENT_NUM_LANES 4

// transmit counters, qword count at index 0 and event count at index 1
`define EVENT_NUM_TX_COUNTS 2

// memclk cycles between the ddr reset request and the reset seen
// by the memory controller
`define EVENT_DDR_RESET_DELAY 16

`endif

//--- source/event_register_core.sv
`timescale 1ns/10ps

`include "event_ctrl_config.svh"

module event_register_core (
    input  logic                          memclk,
    input  logic                          arst_n_i,

    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  event_bus_pkg::wb_addr_t       wb_adr_i,
    input  event_bus_pkg::wb_sel_t        wb_sel_i,
    input  event_bus_pkg::wb_data_t       wb_dat_i,
    output logic                          wb_ack_o,
    output event_bus_pkg::wb_data_t       wb_dat_o,

    input  logic                          event_open_i,
    input  event_stat_pkg::track_err_t    track_err_i,
    input  event_stat_pkg::err_vec_t      lane_err_i,
    input  event_stat_pkg::err_vec_t      mem_err_i,
    input  event_stat_pkg::err_vec_t      readout_err_i,
    input  event_stat_pkg::ack_count_t    ack_count_i,
    input  event_stat_pkg::flow_count_t   allow_count_i,
    input  event_stat_pkg::flow_count_t   cmpl_count_i,
    input  event_stat_pkg::count_t        lane_count_i [`EVENT_NUM_LANES],
    input  event_stat_pkg::count_t        tx_count_i [`EVENT_NUM_TX_COUNTS],

    output logic                          event_reset_o,
    output logic                          ddr_reset_req_o,
    output event_stat_pkg::tio_mask_t     tio_mask_o,
    output event_stat_pkg::runcfg_t       runcfg_o
);

    logic                        req;
    logic                        rd_en;
    logic                        wr_en;
    logic                        is_global;
    event_bus_pkg::reg_index_t   reg_idx;
    event_bus_pkg::wb_data_t     rd_mux;
    event_stat_pkg::glob_reg_t   glob_reg;
    event_stat_pkg::flow_reg_t   flow_reg;

    logic                        ack_q;
    event_bus_pkg::wb_data_t     rdata_q;
    logic                        force_q;
    logic                        event_reset_q;
    logic                        ddr_req_q;
    event_stat_pkg::tio_mask_t   tio_mask_q;
    event_stat_pkg::runcfg_t     runcfg_q;

    event_stat_pkg::track_err_t  track_err_q;
    event_stat_pkg::err_vec_t    lane_err_q;
    event_stat_pkg::err_vec_t    mem_err_q;
    event_stat_pkg::err_vec_t    readout_err_q;
    event_stat_pkg::ack_count_t  ack_count_q;
    event_stat_pkg::flow_count_t allow_count_q;
    event_stat_pkg::flow_count_t cmpl_count_q;

    assign req     = wb_cyc_i & wb_stb_i;
    assign reg_idx = wb_adr_i[5:2];
    // read data is captured in the first cycle, before ack comes up
    assign rd_en   = req & ~wb_we_i & ~ack_q;
    // writes land on the edge that closes the ack cycle
    assign wr_en   = req & wb_we_i & ack_q;
    // indices 0 to 3 all map to the global register
    assign is_global = (reg_idx[3:2] == 2'b00);

    assign glob_reg.rsvd_hi       = '0;
    assign glob_reg.runcfg        = runcfg_q;
    assign glob_reg.track_err     = track_err_q;
    assign glob_reg.tio_mask      = tio_mask_q;
    assign glob_reg.rsvd_lo       = '0;
    assign glob_reg.ddr_reset_req = ddr_req_q;
    assign glob_reg.event_reset   = event_reset_q;
    assign glob_reg.force_reset   = force_q;

    assign flow_reg.rsvd_hi     = '0;
    assign flow_reg.allow_count = allow_count_q;
    assign flow_reg.rsvd_lo     = '0;
    assign flow_reg.ack_count   = ack_count_q;

    always_comb begin
        case (reg_idx)
            event_bus_pkg::REG_LANE_CNT0:      rd_mux = lane_count_i[0];
            event_bus_pkg::REG_LANE_CNT1:      rd_mux = lane_count_i[1];
            event_bus_pkg::REG_LANE_CNT2:      rd_mux = lane_count_i[2];
            event_bus_pkg::REG_LANE_CNT3:      rd_mux = lane_count_i[3];
            event_bus_pkg::REG_QWORD_CNT:      rd_mux = tx_count_i[0];
            event_bus_pkg::REG_EVENT_CNT:      rd_mux = tx_count_i[1];
            event_bus_pkg::REG_FLOW_CNT:       rd_mux = flow_reg;
            event_bus_pkg::REG_LANE_ERR:       rd_mux = lane_err_q;
            event_bus_pkg::REG_MEM_ERR:        rd_mux = mem_err_q;
            event_bus_pkg::REG_READOUT_ERR:    rd_mux = readout_err_q;
            event_bus_pkg::REG_CMPL_CNT:       rd_mux = {19'd0, cmpl_count_q};
            event_bus_pkg::REG_LANE_CNT3_COPY: rd_mux = lane_count_i[3];
            default:                           rd_mux = glob_reg;
        endcase
    end

    // bus handshake and control bits
    always_ff @(posedge memclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q         <= 1'b0;
            rdata_q       <= '0;
            force_q       <= 1'b0;
            event_reset_q <= 1'b0;
            ddr_req_q     <= 1'b0;
            tio_mask_q    <= '0;
            runcfg_q      <= '0;
        end else begin
            ack_q <= req;
            if (rd_en) begin
                rdata_q <= rd_mux;
            end
            if (wr_en && is_global) begin
                if (wb_sel_i[0]) begin
                    force_q   <= wb_dat_i[0];
                    ddr_req_q <= wb_dat_i[2];
                end
                if (wb_sel_i[1]) begin
                    tio_mask_q <= wb_dat_i[11:8];
                end
                if (wb_sel_i[2]) begin
                    runcfg_q[7:0] <= wb_dat_i[23:16];
                end
                if (wb_sel_i[3]) begin
                    runcfg_q[11:8] <= wb_dat_i[27:24];
                end
            end
            // statistics are held clear while no event is open
            event_reset_q <= force_q | ~event_open_i;
        end
    end

    // status sampling, one cycle of latency
    always_ff @(posedge memclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            track_err_q   <= '0;
            lane_err_q    <= '0;
            mem_err_q     <= '0;
            readout_err_q <= '0;
            ack_count_q   <= '0;
            allow_count_q <= '0;
            cmpl_count_q  <= '0;
        end else begin
            track_err_q   <= track_err_i;
            lane_err_q    <= lane_err_i;
            mem_err_q     <= mem_err_i;
            readout_err_q <= readout_err_i;
            ack_count_q   <= ack_count_i;
            allow_count_q <= allow_count_i;
            cmpl_count_q  <= cmpl_count_i;
        end
    end

    assign wb_ack_o        = ack_q & req;
    assign wb_dat_o        = rdata_q;
    assign event_reset_o   = event_reset_q;
    assign ddr_reset_req_o = ddr_req_q;
    assign tio_mask_o      = tio_mask_q;
    assign runcfg_o        = runcfg_q;

endmodule

//--- source/event_stat_counter.sv
`timescale 1ns/10ps

module event_stat_counter #(
    parameter int NUM_COUNTS = 1
) (
    input  logic                  memclk,
    input  logic                  arst_n_i,
    input  logic                  clear_i,
    input  logic [NUM_COUNTS-1:0] valid_i,
    output event_stat_pkg::count_t count_o [NUM_COUNTS]
);

    event_stat_pkg::count_t count_q [NUM_COUNTS];

    // one free-running count per valid bit, wraps at 2^32
    always_ff @(posedge memclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_COUNTS; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_COUNTS; i++) begin
                // clear wins over a valid in the same cycle
                if (clear_i) begin
                    count_q[i] <= '0;
                end else if (valid_i[i]) begin
                    count_q[i] <= count_q[i] + 32'd1;
                end
            end
        end
    end

    assign count_o = count_q;

endmodule

//--- source/event_stat_pkg.sv
package event_stat_pkg;

    typedef logic [31:0] count_t;
    typedef logic [3:0]  lane_valid_t;
    typedef logic [31:0] err_vec_t;
    typedef logic [11:0] runcfg_t;
    typedef logic [3:0]  tio_mask_t;
    typedef logic [3:0]  track_err_t;
    typedef logic [11:0] ack_count_t;
    // shared by the allow and completion counts
    typedef logic [12:0] flow_count_t;

    // layout of the global control/status register
    typedef struct packed {
        logic [3:0] rsvd_hi;
        runcfg_t    runcfg;
        track_err_t track_err;
        tio_mask_t  tio_mask;
        logic [4:0] rsvd_lo;
        logic       ddr_reset_req;
        logic       event_reset;
        logic       force_reset;
    } glob_reg_t;

    // ack count low, allow count in the upper half
    typedef struct packed {
        logic [2:0]  rsvd_hi;
        flow_count_t allow_count;
        logic [3:0]  rsvd_lo;
        ack_count_t  ack_count;
    } flow_reg_t;

endpackage

//--- src.f
+incdir+source
source/event_bus_pkg.sv
source/event_stat_pkg.sv
source/event_stat_counter.sv
source/ddr_reset_delay.sv
source/event_register_core.sv
source/event_control_top.sv
sim/tb_event_control.sv
